/* hdl/core_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~
// shared types, opcodes and record layouts of the rv32i pipeline
// imported by every rtl module and by the testbench
//~~~~~~~~~~~~~~~~~~~~
package core_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [2:0] {
        OP_ALU_REG,
        OP_ALU_IMM,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_ILLEGAL
    } op_class_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // major opcodes of the kept formats
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // branch conditions in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } fetch_rec_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        op_class_t       op_class;
        alu_op_t         alu_op;
        logic [2:0]      funct3;
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        logic [xlen-1:0] imm;     // sign extended
        logic [xlen-1:0] link;    // pc + 4
        logic            rd_wen;
        logic            valid;
    } decode_rec_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        reg_idx_t        rd;
        logic            wen;
        logic [xlen-1:0] wdata;
        logic [xlen-1:0] next_pc;
        logic            illegal;
    } retire_rec_t;

endpackage

/* hdl/inst_buffer.sv */
//~~~~~~~~~~~~~~~~~~~~
// input fifo of the core, filled by a credit holding sender
//~~~~~~~~~~~~~~~~~~~~
module inst_buffer import core_pkg::*; #(
    parameter int in_depth = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  fetch_rec_t in_rec,
    input  logic       pop,
    output logic       buf_valid,
    output fetch_rec_t buf_rec,
    output logic       in_credit
);
    localparam int ptr_w = $clog2(in_depth);
    localparam int cnt_w = $clog2(in_depth + 1);

    fetch_rec_t mem [in_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic full;
    logic do_pop;

    assign full      = (count == cnt_w'(in_depth));
    assign buf_valid = (count != '0);
    assign buf_rec   = mem[rd_ptr];
    assign do_pop    = pop && buf_valid;

    always_ff @(posedge clk) begin
        if (in_valid) mem[wr_ptr] <= in_rec;
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count     <= count + cnt_w'(in_valid) - cnt_w'(do_pop);
            in_credit <= do_pop;  // one credit back per drained entry
        end
    end

    // sender must never push without a credit
    assert property (@(posedge clk) disable iff (reset) in_valid |-> !full)
        else $error("inst_buffer: push into full fifo, credit violation");

endmodule

/* hdl/decode_stage.sv */
//~~~~~~~~~~~~~~~~~~~~
// decodes the buffer head into a registered decode record
//~~~~~~~~~~~~~~~~~~~~
module decode_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        buf_valid,
    input  fetch_rec_t  buf_rec,
    input  logic        advance,
    output logic        pop,
    output decode_rec_t dec
);
    logic [31:0] inst;
    logic [6:0]  opcode;
    logic [6:0]  funct7;
    logic [2:0]  funct3;
    op_class_t   op_class;
    alu_op_t     alu_op;
    logic [xlen-1:0] imm;
    decode_rec_t nxt;

    assign inst   = buf_rec.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        unique case (opcode)
            OPC_OP:     op_class = OP_ALU_REG;
            OPC_OP_IMM: op_class = OP_ALU_IMM;
            OPC_LUI:    op_class = OP_LUI;
            OPC_AUIPC:  op_class = OP_AUIPC;
            OPC_JAL:    op_class = OP_JAL;
            OPC_JALR:   op_class = OP_JALR;
            OPC_BRANCH: op_class = OP_BRANCH;
            default:    op_class = OP_ILLEGAL;  // loads, stores, system
        endcase
    end

    always_comb begin
        unique case (op_class)
            OP_ALU_IMM, OP_JALR: imm = {{20{inst[31]}}, inst[31:20]};
            OP_LUI, OP_AUIPC:    imm = {inst[31:12], 12'b0};
            OP_JAL:    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            OP_BRANCH: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            default:   imm = '0;
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;  // address and upper-imm forms add
        if (op_class == OP_ALU_REG || op_class == OP_ALU_IMM) begin
            unique case (funct3)
                3'b000: begin
                    // no subi, so sub only in register form
                    if (op_class == OP_ALU_REG && funct7[5]) alu_op = ALU_SUB;
                end
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;  // srai shares the bit
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        nxt.pc       = buf_rec.pc;
        nxt.op_class = op_class;
        nxt.alu_op   = alu_op;
        nxt.funct3   = funct3;
        nxt.rd       = inst[11:7];
        nxt.rs1      = inst[19:15];
        nxt.rs2      = inst[24:20];
        nxt.imm      = imm;
        nxt.link     = buf_rec.pc + xlen'(4);
        nxt.rd_wen   = !(op_class == OP_BRANCH || op_class == OP_ILLEGAL);
        nxt.valid    = 1'b1;
    end

    // take the head when the slot is empty or drains this cycle
    assign pop = buf_valid && (!dec.valid || advance);

    always_ff @(posedge clk) begin
        if (reset) begin
            dec.valid <= 1'b0;
        end else if (pop) begin
            dec <= nxt;
        end else if (advance) begin
            dec.valid <= 1'b0;
        end
    end

endmodule

/* hdl/reg_file.sv */
//~~~~~~~~~~~~~~~~~~~~
// 32 x xlen integer registers, x0 reads as zero
//~~~~~~~~~~~~~~~~~~~~
module reg_file import core_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            wen,
    input  reg_idx_t        waddr,
    input  logic [xlen-1:0] wdata,
    input  reg_idx_t        raddr1,
    input  reg_idx_t        raddr2,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2
);
    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* hdl/alu.sv */
//~~~~~~~~~~~~~~~~~~~~
// combinational integer alu for the execute stage
//~~~~~~~~~~~~~~~~~~~~
module alu import core_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_t         op,
    output logic [xlen-1:0] result
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        unique case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = xlen'($signed(a) < $signed(b));
            ALU_SLTU: result = xlen'(a < b);
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

/* hdl/execute_stage.sv */
//~~~~~~~~~~~~~~~~~~~~
// executes the decode record, writes back and emits the retire record
// fires only while output credits remain
//~~~~~~~~~~~~~~~~~~~~
module execute_stage import core_pkg::*; #(
    parameter int out_credits = 2
) (
    input  logic            clk,
    input  logic            reset,
    input  decode_rec_t     dec,
    input  logic [xlen-1:0] rdata1,
    input  logic [xlen-1:0] rdata2,
    input  logic            out_credit,
    output logic            advance,
    output logic            rf_wen,
    output reg_idx_t        rf_waddr,
    output logic [xlen-1:0] rf_wdata,
    output logic            retire_valid,
    output retire_rec_t     retire
);
    // one spare count so a credit overrun stays visible
    localparam int cr_w = $clog2(out_credits + 2);

    logic [cr_w-1:0] credits;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] next_pc;
    logic            taken;
    logic            fire;
    retire_rec_t     rec;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_y)
    );

    always_comb begin
        unique case (dec.op_class)
            OP_ALU_REG: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
            OP_LUI: begin
                alu_a = '0;
                alu_b = dec.imm;
            end
            OP_AUIPC, OP_JAL, OP_BRANCH: begin
                alu_a = dec.pc;  // pc relative target
                alu_b = dec.imm;
            end
            default: begin  // alu imm, jalr
                alu_a = rdata1;
                alu_b = dec.imm;
            end
        endcase
    end

    always_comb begin
        unique case (dec.funct3)
            F3_BEQ:  taken = (rdata1 == rdata2);
            F3_BNE:  taken = (rdata1 != rdata2);
            F3_BLT:  taken = ($signed(rdata1) < $signed(rdata2));
            F3_BGE:  taken = ($signed(rdata1) >= $signed(rdata2));
            F3_BLTU: taken = (rdata1 < rdata2);
            F3_BGEU: taken = (rdata1 >= rdata2);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        next_pc = dec.link;
        wdata   = alu_y;
        unique case (dec.op_class)
            OP_JAL: begin
                next_pc = alu_y;
                wdata   = dec.link;
            end
            OP_JALR: begin
                next_pc = {alu_y[xlen-1:1], 1'b0};
                wdata   = dec.link;
            end
            OP_BRANCH: if (taken) next_pc = alu_y;
            default: ;
        endcase
    end

    always_comb begin
        rec.pc      = dec.pc;
        rec.rd      = dec.rd;
        rec.wen     = dec.rd_wen;
        rec.wdata   = wdata;
        rec.next_pc = next_pc;
        rec.illegal = (dec.op_class == OP_ILLEGAL);
    end

    assign fire    = dec.valid && (credits != '0);
    assign advance = fire;

    // regfile write lands on the same edge as the retire capture
    assign rf_wen   = fire && dec.rd_wen;
    assign rf_waddr = dec.rd;
    assign rf_wdata = wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= cr_w'(out_credits);
        end else begin
            unique case ({fire, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;  // spend and return cancel
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) retire_valid <= 1'b0;
        else retire_valid <= fire;
    end

    always_ff @(posedge clk) begin
        if (fire) retire <= rec;
    end

    // downstream may not return more credits than it was given
    assert property (@(posedge clk) disable iff (reset) int'(credits) <= out_credits)
        else $error("execute_stage: output credit count above %0d", out_credits);

endmodule

/* hdl/core_top.sv */
//~~~~~~~~~~~~~~~~~~~~
// rv32i core top, buffer -> decode -> execute with credit channels
//~~~~~~~~~~~~~~~~~~~~
module core_top import core_pkg::*; #(
    parameter int in_depth    = 4,
    parameter int out_credits = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  fetch_rec_t  in_rec,
    output logic        in_credit,
    output logic        retire_valid,
    output retire_rec_t retire,
    input  logic        out_credit
);
    logic            buf_valid;
    fetch_rec_t      buf_rec;
    logic            pop;
    logic            advance;
    decode_rec_t     dec;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic            rf_wen;
    reg_idx_t        rf_waddr;
    logic [xlen-1:0] rf_wdata;

    inst_buffer #(
        .in_depth (in_depth)
    ) u_inst_buffer (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_rec    (in_rec),
        .pop       (pop),
        .buf_valid (buf_valid),
        .buf_rec   (buf_rec),
        .in_credit (in_credit)
    );

    decode_stage u_decode_stage (
        .clk       (clk),
        .reset     (reset),
        .buf_valid (buf_valid),
        .buf_rec   (buf_rec),
        .advance   (advance),
        .pop       (pop),
        .dec       (dec)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    execute_stage #(
        .out_credits (out_credits)
    ) u_execute_stage (
        .clk          (clk),
        .reset        (reset),
        .dec          (dec),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .out_credit   (out_credit),
        .advance      (advance),
        .rf_wen       (rf_wen),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

/* dv/core_tb.sv */
//~~~~~~~~~~~~~~~~~~~~
// testbench for core_top, replays dv/core_trace.hex through both credit channels
// random input gaps and slow output credit returns
//~~~~~~~~~~~~~~~~~~~~
module core_tb import core_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int in_depth       = 4;
    localparam int out_credits    = 2;
    localparam int n_inst         = 30;
    localparam int n_cols         = 7;   // pc inst rd wen wdata next_pc illegal
    localparam int timeout_cycles = 2000;

    logic        clk;
    logic        reset;
    logic        in_valid;
    fetch_rec_t  in_rec;
    logic        in_credit;
    logic        retire_valid;
    retire_rec_t retire;
    logic        out_credit;

    logic [31:0] trace_mem [n_inst*n_cols];
    logic [31:0] lfsr_state;

    int send_idx;
    int in_credits_held;   // sender side credit count
    int in_credit_cnt;
    int retire_cnt;
    int owed_credits;      // retires consumed but not yet returned
    int returned_cnt;
    int retire_errors;
    int flow_errors;
    int count_errors;
    int timeout_errors;

    core_top #(
        .in_depth    (in_depth),
        .out_credits (out_credits)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_rec       (in_rec),
        .in_credit    (in_credit),
        .retire_valid (retire_valid),
        .retire       (retire),
        .out_credit   (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [3:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[2:0], lfsr_state[0]};
        end
    endtask

    function automatic fetch_rec_t stim_rec(input int idx);
        fetch_rec_t r;
        r.pc   = trace_mem[idx*n_cols];
        r.inst = trace_mem[idx*n_cols + 1];
        return r;
    endfunction

    function automatic retire_rec_t exp_rec(input int idx);
        retire_rec_t r;
        int base;
        base      = idx * n_cols;
        r.pc      = trace_mem[base];
        r.rd      = trace_mem[base + 2][4:0];
        r.wen     = trace_mem[base + 3][0];
        r.wdata   = trace_mem[base + 4];
        r.next_pc = trace_mem[base + 5];
        r.illegal = trace_mem[base + 6][0];
        return r;
    endfunction

    task automatic report_field(input string name, input int idx,
                                input logic [31:0] got, input logic [31:0] exp);
        $display("CHECK FAILED %s (record %0d) got 0x%08h expected 0x%08h",
                 name, idx, got, exp);
        retire_errors++;
    endtask

    task automatic check_retire(input retire_rec_t got, input retire_rec_t exp, input int idx);
        if (got.pc !== exp.pc) report_field("retire.pc", idx, got.pc, exp.pc);
        if (got.wen !== exp.wen) report_field("retire.wen", idx, 32'(got.wen), 32'(exp.wen));
        if (got.next_pc !== exp.next_pc)
            report_field("retire.next_pc", idx, got.next_pc, exp.next_pc);
        if (got.illegal !== exp.illegal)
            report_field("retire.illegal", idx, 32'(got.illegal), 32'(exp.illegal));
        // rd and wdata are don't care without a write
        if (exp.wen && got.rd !== exp.rd) report_field("retire.rd", idx, 32'(got.rd), 32'(exp.rd));
        if (exp.wen && got.wdata !== exp.wdata)
            report_field("retire.wdata", idx, got.wdata, exp.wdata);
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            count_errors++;
        end
    endtask

    // upstream sender and downstream credit return, one draw order per cycle
    always @(posedge clk) begin
        logic [3:0] send_bits;
        logic [3:0] ret_bits;
        if (reset) begin
            in_valid   <= 1'b0;
            out_credit <= 1'b0;
        end else begin
            draw_bits(2, send_bits);
            draw_bits(2, ret_bits);
            if (send_idx < n_inst && in_credits_held > 0 && send_bits != 4'd0) begin
                in_valid <= 1'b1;
                in_rec   <= stim_rec(send_idx);
                in_credits_held--;
                send_idx++;
            end else begin
                in_valid <= 1'b0;
            end
            if (owed_credits > 0 && ret_bits == 4'd3) begin  // returns held back most cycles
                out_credit <= 1'b1;
                owed_credits--;
                returned_cnt++;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    // outputs sampled mid cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (in_credit) begin
                in_credit_cnt++;
                in_credits_held++;
            end
            if (retire_valid) begin
                if (retire_cnt + 1 > returned_cnt + out_credits) begin
                    $display("retire %0d issued without an output credit", retire_cnt);
                    flow_errors++;
                end
                if (retire_cnt < n_inst) begin
                    check_retire(retire, exp_rec(retire_cnt), retire_cnt);
                end else begin
                    $display("extra retire record beyond the end of the trace");
                    flow_errors++;
                end
                retire_cnt++;
                owed_credits++;
            end
        end
    end

    task automatic wait_for_retires();
        int cycles;
        cycles = 0;
        while (retire_cnt < n_inst && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (retire_cnt < n_inst) begin
            $display("timeout: only %0d of %0d instructions retired", retire_cnt, n_inst);
            timeout_errors++;
        end
    endtask

    task automatic wait_for_credits();
        int cycles;
        cycles = 0;
        while (in_credit_cnt < n_inst && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (in_credit_cnt < n_inst) begin
            $display("timeout: only %0d input credits came back", in_credit_cnt);
            timeout_errors++;
        end
    endtask

    task automatic end_run();
        int total;
        total = retire_errors + flow_errors + count_errors + timeout_errors;
        $display("errors: retire %0d, flow %0d, count %0d, timeout %0d",
                 retire_errors, flow_errors, count_errors, timeout_errors);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        reset           = 1'b1;
        in_valid        = 1'b0;
        in_rec          = '0;
        out_credit      = 1'b0;
        lfsr_state      = 32'h90c;
        send_idx        = 0;
        in_credits_held = in_depth;
        in_credit_cnt   = 0;
        retire_cnt      = 0;
        owed_credits    = 0;
        returned_cnt    = 0;
        retire_errors   = 0;
        flow_errors     = 0;
        count_errors    = 0;
        timeout_errors  = 0;
        $readmemh("dv/core_trace.hex", trace_mem);
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        wait_for_retires();
        if (timeout_errors == 0) wait_for_credits();
        check_count("retire_count", retire_cnt, n_inst);
        check_count("in_credit_count", in_credit_cnt, n_inst);
        end_run();
    end

endmodule

/* dv/core_trace.hex */
// columns: pc inst | expected rd wen wdata next_pc illegal
// rd and wdata are ignored where wen is 0
00000100 00500093 01 1 00000005 00000104 0
00000104 ffd00113 02 1 fffffffd 00000108 0
00000108 002081b3 03 1 00000002 0000010c 0
0000010c 40208233 04 1 00000008 00000110 0
00000110 401152b3 05 1 ffffffff 00000114 0
00000114 00115333 06 1 07ffffff 00000118 0
00000118 40115393 07 1 fffffffe 0000011c 0
0000011c 0020b433 08 1 00000001 00000120 0
00000120 001124b3 09 1 00000001 00000124 0
00000124 0f00c513 0a 1 000000f5 00000128 0
00000128 0020e5b3 0b 1 fffffffd 0000012c 0
0000012c 0ff17613 0c 1 000000fd 00000130 0
00000130 00409693 0d 1 00000050 00000134 0
00000134 abcde737 0e 1 abcde000 00000138 0
00000138 00001797 0f 1 00001138 0000013c 0
0000013c 00708013 00 1 0000000c 00000140 0
00000140 00100833 10 1 00000005 00000144 0
00000144 00108463 00 0 00000000 0000014c 0
0000014c 00109463 00 0 00000000 00000150 0
00000150 00114663 00 0 00000000 0000015c 0
0000015c 00115463 00 0 00000000 00000160 0
00000160 00116463 00 0 00000000 00000164 0
00000164 fe1178e3 00 0 00000000 00000154 0
00000154 020008ef 11 1 00000158 00000174 0
00000174 10008967 12 1 00000178 00000104 0
00000104 0000a983 00 0 00000000 00000108 1
00000108 0020a023 00 0 00000000 0000010c 1
0000010c 00000073 00 0 00000000 00000110 1
00000110 00098a33 14 1 00000000 00000114 0
00000114 ffc88ae7 15 1 00000118 00000154 0

/* tb.f */
hdl/core_pkg.sv
hdl/inst_buffer.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/execute_stage.sv
hdl/core_top.sv
dv/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the core testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module core_tb -f tb.f -o core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$log"; then
    exit 0
fi
exit 1
